/* holy_core_pkg.sv */
`default_nettype none

package holy_core_pkg;

    localparam int XLEN       = 32;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // Second adder operand selection
    localparam logic [1:0] SECOND_ADD_PC  = 2'b00;
    localparam logic [1:0] SECOND_ADD_IMM = 2'b01;
    localparam logic [1:0] SECOND_ADD_REG = 2'b10;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_src_t;

    typedef enum logic [1:0] {
        WB_ALU    = 2'd0,
        WB_LOAD   = 2'd1,
        WB_PC4    = 2'd2,
        WB_SECOND = 2'd3
    } wb_src_t;

    typedef struct packed {
        alu_op_t    alu_op;
        imm_src_t   imm_src;
        logic       alu_use_imm;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        wb_src_t    wb_src;
        logic       pc_jump;
        logic [1:0] second_add_src;
    } ctrl_t;

    // Register view, addresses and decode fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_reg_t;

    // Immediate view, raw fields for the sign extender
    typedef struct packed {
        logic [11:0] imm_hi;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu
    import holy_core_pkg::*;
(
    input  alu_op_t              i_op,
    input  wire logic [XLEN-1:0] i_a,
    input  wire logic [XLEN-1:0] i_b,
    output logic      [XLEN-1:0] o_result,
    output logic                 o_zero,
    output logic                 o_lt,
    output logic                 o_ltu
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    // Compare flags, independent of the operation
    assign o_lt  = $signed(i_a) < $signed(i_b);
    assign o_ltu = i_a < i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLT:  o_result = {31'd0, o_lt};
            ALU_SLTU: o_result = {31'd0, o_ltu};
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
            default:  o_result = '0;
        endcase
    end

    // Equality for branches, valid with the sub operation
    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

/* signext.sv */
`default_nettype none

module signext
    import holy_core_pkg::*;
(
    input  instr_u          i_instr,
    input  imm_src_t        i_imm_src,
    output logic [XLEN-1:0] o_imm
);

    logic [11:0] hi;
    logic [4:0]  lo;
    logic [7:0]  mid;

    assign hi  = i_instr.i.imm_hi;
    assign lo  = i_instr.i.imm_lo;
    // Bits 19:12 of the word, used by U and J
    assign mid = {i_instr.i.rs1, i_instr.i.funct3};

    always_comb begin
        case (i_imm_src)
            IMM_I:   o_imm = {{20{hi[11]}}, hi};
            IMM_S:   o_imm = {{20{hi[11]}}, hi[11:5], lo};
            IMM_B:   o_imm = {{20{hi[11]}}, lo[0], hi[10:5], lo[4:1], 1'b0};
            IMM_U:   o_imm = {hi, mid, 12'd0};
            IMM_J:   o_imm = {{12{hi[11]}}, mid, hi[0], hi[10:1], 1'b0};
            default: o_imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* regfile.sv */
`default_nettype none

module regfile
    import holy_core_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic [4:0]      i_rs1,
    input  wire logic [4:0]      i_rs2,
    output logic      [XLEN-1:0] o_rd1,
    output logic      [XLEN-1:0] o_rd2,
    input  wire logic            i_we,
    input  wire logic [4:0]      i_rd,
    input  wire logic [XLEN-1:0] i_wdata
);

    logic [XLEN-1:0] regs [32];

    assign o_rd1 = regs[i_rs1];
    assign o_rd2 = regs[i_rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (i_we && i_rd != 5'd0) begin
            // x0 never written, so it reads as zero
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

/* control.sv */
`default_nettype none

module control
    import holy_core_pkg::*;
(
    input  opcode_t         i_opcode,
    input  wire logic [2:0] i_funct3,
    input  wire logic [6:0] i_funct7,
    input  wire logic       i_alu_zero,
    input  wire logic       i_alu_lt,
    input  wire logic       i_alu_ltu,
    output ctrl_t           o_ctrl
);

    alu_op_t alu_op_dec;
    logic    branch_taken;

    // Arithmetic decode shared by register and immediate forms
    always_comb begin
        case (i_funct3)
            3'b000:  alu_op_dec = (i_opcode == OP_REG && i_funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op_dec = ALU_SLL;
            3'b010:  alu_op_dec = ALU_SLT;
            3'b011:  alu_op_dec = ALU_SLTU;
            3'b100:  alu_op_dec = ALU_XOR;
            3'b101:  alu_op_dec = i_funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op_dec = ALU_OR;
            default: alu_op_dec = ALU_AND;
        endcase
    end

    // Branch condition from the compare flags
    always_comb begin
        case (i_funct3)
            3'b000:  branch_taken = i_alu_zero;
            3'b001:  branch_taken = !i_alu_zero;
            3'b100:  branch_taken = i_alu_lt;
            3'b101:  branch_taken = !i_alu_lt;
            3'b110:  branch_taken = i_alu_ltu;
            3'b111:  branch_taken = !i_alu_ltu;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        o_ctrl.alu_op         = ALU_ADD;
        o_ctrl.imm_src        = IMM_I;
        o_ctrl.alu_use_imm    = 1'b0;
        o_ctrl.mem_read       = 1'b0;
        o_ctrl.mem_write      = 1'b0;
        o_ctrl.reg_write      = 1'b0;
        o_ctrl.wb_src         = WB_ALU;
        o_ctrl.pc_jump        = 1'b0;
        o_ctrl.second_add_src = SECOND_ADD_PC;

        case (i_opcode)
            OP_REG: begin
                o_ctrl.alu_op    = alu_op_dec;
                o_ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                o_ctrl.alu_op      = alu_op_dec;
                o_ctrl.alu_use_imm = 1'b1;
                o_ctrl.reg_write   = 1'b1;
            end
            OP_LOAD: begin
                o_ctrl.alu_use_imm = 1'b1;
                o_ctrl.mem_read    = 1'b1;
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.wb_src      = WB_LOAD;
            end
            OP_STORE: begin
                o_ctrl.imm_src     = IMM_S;
                o_ctrl.alu_use_imm = 1'b1;
                o_ctrl.mem_write   = 1'b1;
            end
            OP_BRANCH: begin
                o_ctrl.alu_op  = ALU_SUB;
                o_ctrl.imm_src = IMM_B;
                o_ctrl.pc_jump = branch_taken;
            end
            OP_JAL: begin
                o_ctrl.imm_src   = IMM_J;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_src    = WB_PC4;
                o_ctrl.pc_jump   = 1'b1;
            end
            OP_JALR: begin
                o_ctrl.reg_write      = 1'b1;
                o_ctrl.wb_src         = WB_PC4;
                o_ctrl.pc_jump        = 1'b1;
                o_ctrl.second_add_src = SECOND_ADD_REG;
            end
            // lui and auipc take their result from the second adder
            OP_LUI: begin
                o_ctrl.imm_src        = IMM_U;
                o_ctrl.reg_write      = 1'b1;
                o_ctrl.wb_src         = WB_SECOND;
                o_ctrl.second_add_src = SECOND_ADD_IMM;
            end
            OP_AUIPC: begin
                o_ctrl.imm_src   = IMM_U;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.wb_src    = WB_SECOND;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* load_store_unit.sv */
`default_nettype none

module load_store_unit
    import holy_core_pkg::*;
(
    input  wire logic            clk,
    input  wire logic [XLEN-1:0] i_addr,
    input  wire logic [XLEN-1:0] i_wdata,
    input  wire logic [2:0]      i_funct3,
    input  wire logic            i_mem_read,
    input  wire logic            i_mem_write,
    output logic      [XLEN-1:0] o_rdata
);

    logic [XLEN-1:0]    ram [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [1:0]         byte_off;
    logic [3:0]         byte_en;
    logic [XLEN-1:0]    lane_data;
    logic [XLEN-1:0]    word;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;
    logic [XLEN-1:0]    ld_ext;

    assign word_idx = i_addr[DMEM_AW+1:2];
    assign byte_off = i_addr[1:0];

    // Store lanes, data replicated so every lane carries it
    always_comb begin
        case (i_funct3[1:0])
            2'b00: begin
                byte_en   = 4'b0001 << byte_off;
                lane_data = {4{i_wdata[7:0]}};
            end
            2'b01: begin
                byte_en   = byte_off[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_wdata[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                lane_data = i_wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    ram[word_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // Load path, combinational read
    assign word    = ram[word_idx];
    assign ld_byte = word[{byte_off, 3'b000} +: 8];
    assign ld_half = byte_off[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (i_funct3)
            3'b000:  ld_ext = {{24{ld_byte[7]}}, ld_byte};
            3'b001:  ld_ext = {{16{ld_half[15]}}, ld_half};
            3'b100:  ld_ext = {24'd0, ld_byte};
            3'b101:  ld_ext = {16'd0, ld_half};
            default: ld_ext = word;
        endcase
    end

    assign o_rdata = i_mem_read ? ld_ext : '0;

endmodule

`default_nettype wire

/* holy_core.sv */
`default_nettype none

module holy_core
    import holy_core_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic [XLEN-1:0] i_instr,
    output logic      [XLEN-1:0] o_pc,
    output wb_t                  o_wb
);

    instr_u          instr;
    opcode_t         opcode;
    ctrl_t           ctrl;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_plus_four;
    logic [XLEN-1:0] second_add;

    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic            alu_lt;
    logic            alu_ltu;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;

    assign instr  = i_instr;
    assign opcode = opcode_t'(instr.r.opcode);

    // Program counter
    assign pc_plus_four = pc + 32'd4;

    always_comb begin
        case (ctrl.second_add_src)
            SECOND_ADD_IMM: second_add = imm;
            // jalr target, bit 0 dropped
            SECOND_ADD_REG: second_add = (rd1 + imm) & ~32'd1;
            default:        second_add = pc + imm;
        endcase
    end

    assign pc_next = ctrl.pc_jump ? second_add : pc_plus_four;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign o_pc = pc;

    control u_control (
        .i_opcode  (opcode),
        .i_funct3  (instr.r.funct3),
        .i_funct7  (instr.r.funct7),
        .i_alu_zero(alu_zero),
        .i_alu_lt  (alu_lt),
        .i_alu_ltu (alu_ltu),
        .o_ctrl    (ctrl)
    );

    signext u_signext (
        .i_instr  (instr),
        .i_imm_src(ctrl.imm_src),
        .o_imm    (imm)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_rs1  (instr.r.rs1),
        .i_rs2  (instr.r.rs2),
        .o_rd1  (rd1),
        .o_rd2  (rd2),
        .i_we   (ctrl.reg_write),
        .i_rd   (instr.r.rd),
        .i_wdata(wb_data)
    );

    assign alu_b = ctrl.alu_use_imm ? imm : rd2;

    alu u_alu (
        .i_op    (ctrl.alu_op),
        .i_a     (rd1),
        .i_b     (alu_b),
        .o_result(alu_result),
        .o_zero  (alu_zero),
        .o_lt    (alu_lt),
        .o_ltu   (alu_ltu)
    );

    // Nothing may land in the RAM while the core is held in reset
    load_store_unit u_lsu (
        .clk        (clk),
        .i_addr     (alu_result),
        .i_wdata    (rd2),
        .i_funct3   (instr.r.funct3),
        .i_mem_read (ctrl.mem_read),
        .i_mem_write(ctrl.mem_write & rst_n),
        .o_rdata    (load_data)
    );

    // Write-back selection
    always_comb begin
        case (ctrl.wb_src)
            WB_LOAD:   wb_data = load_data;
            WB_PC4:    wb_data = pc_plus_four;
            WB_SECOND: wb_data = second_add;
            default:   wb_data = alu_result;
        endcase
    end

    assign o_wb.valid = rst_n & ctrl.reg_write & (instr.r.rd != 5'd0);
    assign o_wb.rd    = instr.r.rd;
    assign o_wb.data  = wb_data;

endmodule

`default_nettype wire

/* holy_core_assertions.sv */
`default_nettype none

module holy_core_assertions
    import holy_core_pkg::*;
(
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic [XLEN-1:0] i_pc,
    input wb_t                  i_wb
);

    timeunit 1ns;
    timeprecision 1ps;

    // Fetch address must stay on a word boundary
    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) i_pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", i_pc);

    // Writes to x0 never show on the write-back port
    no_x0_write: assert property (@(posedge clk) !(i_wb.valid && i_wb.rd == 5'd0))
        else $error("write-back valid with rd x0");

    // First cycle out of reset fetches from address 0
    pc_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> i_pc == '0)
        else $error("pc not zero after reset: %h", i_pc);

endmodule

`default_nettype wire

/* tb_holy_core.sv */
`default_nettype none

module tb_holy_core
    import holy_core_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_BASE    = 33;
    localparam int MAX_CYCLES  = 500;

    logic            clk;
    logic            rst_n;
    logic            rst_n_q;
    logic [XLEN-1:0] i_instr;
    logic [XLEN-1:0] o_pc;
    wb_t             o_wb;

    logic [XLEN-1:0] words [0:127];
    int              n_rec;
    int              rec_idx;
    int              errors;
    int              group_errors;
    int              group_writes;
    int              tests_passed;
    int              tests_failed;

    holy_core DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_instr(i_instr),
        .o_pc   (o_pc),
        .o_wb   (o_wb)
    );

    bind holy_core holy_core_assertions u_assertions (
        .clk  (clk),
        .rst_n(rst_n),
        .i_pc (o_pc),
        .i_wb (o_wb)
    );

    // Instruction ROM, word addressed
    assign i_instr = words[{2'b00, o_pc[6:2]}];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rec_group(input int idx);
        return int'(words[REC_BASE + 2 * idx][11:8]);
    endfunction

    function automatic string group_name(input int g);
        case (g)
            1:       return "ALU operations";
            2:       return "lui and auipc";
            3:       return "stores and loads";
            4:       return "branches";
            5:       return "jal and jalr";
            default: return "unknown group";
        endcase
    endfunction

    // Compare each retired write with the next expected record
    always @(posedge clk) begin
        if (!rst_n) begin
            // No register write may retire while the core is held in reset
            if (o_wb.valid) begin
                $display("CHECK FAILED at %0t: o_wb.valid got %b expected 0", $time,
                         o_wb.valid);
                errors++;
            end
        end else begin
            // First cycle out of reset fetches from address 0
            if (!rst_n_q && o_pc != '0) begin
                $display("CHECK FAILED at %0t: o_pc got %h expected %h", $time,
                         o_pc, 32'h0000_0000);
                errors++;
            end
            if (o_pc[1:0] != 2'b00) begin
                $display("pc not word aligned at %0t: %h", $time, o_pc);
                errors++;
            end
            if (o_wb.valid && o_wb.rd == 5'd0) begin
                $display("write to x0 reported as valid at %0t", $time);
                errors++;
            end
            if (o_wb.valid && rec_idx >= n_rec) begin
                $display("unexpected extra write at %0t: x%0d = %h", $time, o_wb.rd, o_wb.data);
                errors++;
            end else if (o_wb.valid) begin
                group_writes++;
                if (o_wb.rd != words[REC_BASE + 2 * rec_idx][4:0]) begin
                    $display("CHECK FAILED at %0t: o_wb.rd got %0d expected %0d", $time,
                             o_wb.rd, words[REC_BASE + 2 * rec_idx][4:0]);
                    errors++;
                    group_errors++;
                end
                if (o_wb.data != words[REC_BASE + 2 * rec_idx + 1]) begin
                    $display("CHECK FAILED at %0t: o_wb.data got %h expected %h", $time,
                             o_wb.data, words[REC_BASE + 2 * rec_idx + 1]);
                    errors++;
                    group_errors++;
                end
                // Group finished when the next record starts another one
                if (rec_idx == n_rec - 1 || rec_group(rec_idx + 1) != rec_group(rec_idx)) begin
                    if (group_errors == 0) begin
                        $display("test %0d %s: PASS (%0d writes)", rec_group(rec_idx),
                                 group_name(rec_group(rec_idx)), group_writes);
                        tests_passed++;
                    end else begin
                        $display("test %0d %s: FAIL (%0d mismatches)", rec_group(rec_idx),
                                 group_name(rec_group(rec_idx)), group_errors);
                        tests_failed++;
                    end
                    group_errors = 0;
                    group_writes = 0;
                end
                rec_idx++;
            end
        end
        rst_n_q = rst_n;
    end

    initial begin
        int              cycles;
        int              stable;
        logic [XLEN-1:0] last_pc;
        logic            timed_out;

        rst_n        = 1'b0;
        rst_n_q      = 1'b0;
        rec_idx      = 0;
        errors       = 0;
        group_errors = 0;
        group_writes = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles       = 0;
        stable       = 0;
        last_pc      = '1;
        timed_out    = 1'b0;
        $readmemh("holy_core_testdata.mem", words);
        n_rec = int'(words[32]);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Run until all records are seen or the core parks on its self-loop
        while (rec_idx < n_rec && stable < 2 && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (o_pc == last_pc) begin
                stable++;
            end else begin
                stable = 0;
            end
            last_pc = o_pc;
            if (cycles >= MAX_CYCLES) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("timeout: the program did not finish within %0d cycles", MAX_CYCLES);
            errors++;
        end else if (rec_idx < n_rec) begin
            $display("program stopped after %0d of %0d expected writes", rec_idx, n_rec);
            errors++;
        end
        // Let a stray write after the last record show up
        repeat (2) @(negedge clk);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* holy_core_testdata.mem */
// Words 0..31 program, word 32 record count, then records of {group, rd} and value
// Record rd entry holds the test group in bits 11:8 and the register in bits 4:0
FFB00093 00300113 402081B3 0020A233
0020B2B3 4020D333 0020D3B3 00411413
12345537 00001597 00102023 00101123
008000A3 00002603 00000683 00104703
00201783 00205803 00210463 00100893
00211463 00200893 0020C463 00300893
0020D463 00388893 0020F463 00400893
0040096F 005909E7 00508013 0000006F
// Record count
00000013
// Group 1, ALU register and immediate operations
00000101 FFFFFFFB
00000102 00000003
00000103 FFFFFFF8
00000104 00000001
00000105 00000000
00000106 FFFFFFFF
00000107 1FFFFFFF
00000108 00000030
// Group 2, lui and auipc at word 9
0000020A 12345000
0000020B 00001024
// Group 3, loads after sw, sh and sb
0000030C FFFB30FB
0000030D FFFFFFFB
0000030E 00000030
0000030F FFFFFFFB
00000310 0000FFFB
// Group 4, only the expected branch paths write x17
00000411 00000002
00000411 00000005
// Group 5, jal and jalr link values
00000512 00000074
00000513 00000078

/* list.f */
holy_core_pkg.sv
alu.sv
signext.sv
regfile.sv
control.sv
load_store_unit.sv
holy_core.sv
holy_core_assertions.sv
tb_holy_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the holy_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -sv --assert --top-module tb_holy_core \
    -f list.f --Mdir obj_dir -o sim_holy_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_holy_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
